// ==== sources.f ====
+incdir+.
rpRegPkg.sv
rpCmdPkg.sv
rpdc.sv
rpda.sv
rpCtrl.sv
rpDrive.sv
rpDriveTb.sv

// ==== Bender.yml ====
package:
  name: rp_drive

sources:
  - include_dirs:
      - .
    files:
      - rpRegPkg.sv
      - rpCmdPkg.sv
      - rpdc.sv
      - rpda.sv
      - rpCtrl.sv
      - rpDrive.sv

  - target: test
    include_dirs:
      - .
    files:
      - rpDriveTb.sv

// ==== rpDriveTb.sv ====
////////////////////////////////////////
// RP drive testbench
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

`include "rpDrive_consts.svh"

module rpDriveTb;

   import rpRegPkg::*;

   // Run limits from the operation delays
   localparam int numOps     = 16;
   localparam int opCycles   = `RP_SEEK_CYCLES + `RP_XFER_CYCLES;
   localparam int cycleLimit = 40 * opCycles * numOps;
   localparam int waitLimit  = 4 * opCycles;

   logic   clk;
   logic   rst;
   rpBusT  rpBus;
   regAdrT rdAdr;
   rpWordT rdData;
   logic   attn;

   int          errors     = 0;
   int          checks     = 0;
   int          cycleCount = 0;
   logic [31:0] seed       = 32'hc92b2eb4;

   // Reference model of the disk address
   dcaT  mDc;
   trkT  mTrk;
   sectT mSect;

   rpDrive i_dut
   (
      .clk    (clk),
      .rst    (rst),
      .rpBus  (rpBus),
      .rdAdr  (rdAdr),
      .rdData (rdData),
      .attn   (attn)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Hung run guard
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit)
      begin
         $display("Run did not finish within %0d cycles", cycleLimit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   // LCG step
   function automatic logic [31:0] nextRand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic int randRange(input int n);
      return int'((nextRand() >> 8) % n);
   endfunction

   function automatic rpWordT dsExpect(input logic ata, input logic err, input logic dry);
      rpWordT w;
      w              = '0;
      w[`RP_DS_ATA]  = ata;
      w[`RP_DS_ERR]  = err;
      w[`RP_DS_DRY]  = dry;
      return w;
   endfunction

   // CS1 of a ready drive after a function
   function automatic rpWordT cs1Expect(input logic [4:0] fn);
      rpWordT w;
      w              = '0;
      w[`RP_CS1_FUN] = fn;
      return w;
   endfunction

   // DA word as the model sees it
   function automatic rpWordT daExpect();
      rpWordT w;
      w              = '0;
      w[`RP_DA_TRK]  = mTrk;
      w[`RP_DA_SECT] = mSect;
      return w;
   endfunction

   // Sector step with carry into track, then cylinder
   task automatic modelStep();
      if (mSect == sectT'(`RP_NUM_SECT - 1))
      begin
         mSect = '0;
         if (mTrk == trkT'(`RP_NUM_TRK - 1))
         begin
            mTrk = '0;
            mDc  = mDc + 1'b1;
         end
         else
            mTrk = mTrk + 1'b1;
      end
      else
         mSect = mSect + 1'b1;
   endtask

   // Called on a falling edge and returns on the next one
   task automatic busWrite(input regAdrT adr, input busDataT data);
      rpBus.wr   = 1'b1;
      rpBus.adr  = adr;
      rpBus.data = data;
      @(negedge clk);
      rpBus.wr   = 1'b0;
   endtask

   task automatic goFunc(input logic [4:0] fn);
      busDataT d;
      d                = '0;
      d[`RP_CS1_FUN]   = fn;
      d[`RP_CS1_GO]    = 1'b1;
      busWrite(`RP_ADR_CS1, d);
   endtask

   // Junk outside the field must be dropped
   task automatic writeDc(input dcaT c);
      busDataT d;
      d              = busDataT'({nextRand(), nextRand()});
      d[`RP_DC_DCA]  = c;
      busWrite(`RP_ADR_DC, d);
      mDc = c;
   endtask

   task automatic writeDa(input trkT t, input sectT s);
      busDataT d;
      d              = busDataT'({nextRand(), nextRand()});
      d[`RP_DA_TRK]  = t;
      d[`RP_DA_SECT] = s;
      busWrite(`RP_ADR_DA, d);
      mTrk  = t;
      mSect = s;
   endtask

   task automatic readReg(input regAdrT adr, output rpWordT val);
      rdAdr = adr;
      #1;
      val = rdData;
   endtask

   task automatic checkValue(input string name, input int exp, input int act);
      checks++;
      assert (act == exp)
      else
      begin
         errors++;
         $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic checkReg(input string name, input regAdrT adr, input rpWordT exp);
      rpWordT act;
      readReg(adr, act);
      checks++;
      assert (act === exp)
      else
      begin
         errors++;
         $display("FAIL %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Counts falling edges until DRY is back
   task automatic waitReady(output int n);
      rpWordT ds;
      n = 0;
      readReg(`RP_ADR_DS, ds);
      while (!ds[`RP_DS_DRY] && n < waitLimit)
      begin
         @(negedge clk);
         n++;
         readReg(`RP_ADR_DS, ds);
      end
      if (!ds[`RP_DS_DRY])
      begin
         errors++;
         $display("Drive did not become ready within %0d cycles", waitLimit);
      end
   endtask

   task automatic readCase(input string name);
      int n;
      goFunc(`RP_FN_READ);
      waitReady(n);
      checkValue({name, " cycles"}, `RP_XFER_CYCLES, n);
      modelStep();
      checkReg({name, " DA"}, `RP_ADR_DA, daExpect());
      checkReg({name, " DC"}, `RP_ADR_DC, rpWordT'(mDc));
   endtask

   // Illegal address so GO must not start anything
   task automatic badCase(input string name, input logic [4:0] fn, input dcaT c,
                          input trkT t, input sectT s);
      rpWordT iaeWord;
      iaeWord              = '0;
      iaeWord[`RP_ER1_IAE] = 1'b1;
      writeDc(c);
      writeDa(t, s);
      goFunc(fn);
      checkReg({name, " DS"}, `RP_ADR_DS, dsExpect(1'b0, 1'b1, 1'b1));
      checkReg({name, " ER1"}, `RP_ADR_ER1, iaeWord);
      checkReg({name, " DC"}, `RP_ADR_DC, rpWordT'(mDc));
      goFunc(`RP_FN_DRVCLR);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      int     i;
      int     n;
      rpWordT ds;
      rst   = 1'b1;
      rpBus = '0;
      rdAdr = '0;
      mDc   = '0;
      mTrk  = '0;
      mSect = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset state and masked write-back
      checkReg("reset DS", `RP_ADR_DS, dsExpect(1'b0, 1'b0, 1'b1));
      checkReg("reset ER1", `RP_ADR_ER1, '0);
      checkReg("reset DC", `RP_ADR_DC, '0);
      checkReg("reset DA", `RP_ADR_DA, '0);
      for (i = 0; i < 4; i++)
      begin
         writeDc(dcaT'(randRange(`RP_NUM_CYL)));
         checkReg("write DC", `RP_ADR_DC, rpWordT'(mDc));
         writeDa(trkT'(randRange(`RP_NUM_TRK)), sectT'(randRange(`RP_NUM_SECT)));
         checkReg("write DA", `RP_ADR_DA, daExpect());
      end

      // Seek with a DC write while busy
      writeDc(dcaT'(randRange(`RP_NUM_CYL)));
      goFunc(`RP_FN_SEEK);
      readReg(`RP_ADR_DS, ds);
      checkValue("seek busy DRY", 0, ds[`RP_DS_DRY]);
      checkValue("seek busy attn", 0, attn);
      busWrite(`RP_ADR_DC, busDataT'(~mDc));
      waitReady(n);
      checkValue("seek cycles", `RP_SEEK_CYCLES, n + 1);
      checkValue("seek attn", 1, attn);
      checkReg("seek DS", `RP_ADR_DS, dsExpect(1'b1, 1'b0, 1'b1));
      checkReg("seek CS1", `RP_ADR_CS1, cs1Expect(`RP_FN_SEEK));
      checkReg("unused register", 5'd3, '0);
      checkReg("busy DC write", `RP_ADR_DC, rpWordT'(mDc));
      goFunc(`RP_FN_DRVCLR);

      // Read advance cases
      writeDc(dcaT'(randRange(`RP_NUM_CYL - 1)));
      writeDa(trkT'(randRange(`RP_NUM_TRK)), sectT'(randRange(`RP_NUM_SECT - 1)));
      readCase("read step");
      writeDa(trkT'(randRange(`RP_NUM_TRK - 1)), sectT'(`RP_NUM_SECT - 1));
      readCase("read sector wrap");
      writeDa(trkT'(`RP_NUM_TRK - 1), sectT'(`RP_NUM_SECT - 1));
      readCase("read track wrap");

      // Geometry check on GO
      badCase("bad cylinder", `RP_FN_SEEK, dcaT'(`RP_NUM_CYL), '0, '0);
      badCase("bad track", `RP_FN_READ, '0, trkT'(`RP_NUM_TRK), '0);
      badCase("bad sector", `RP_FN_SEEK, '0, '0, sectT'(`RP_NUM_SECT + 3));

      // Recalibrate over a pending error, then drive clear
      writeDc(dcaT'(`RP_NUM_CYL + 50));
      goFunc(`RP_FN_SEEK);
      goFunc(`RP_FN_RECAL);
      mDc   = '0;
      mTrk  = '0;
      mSect = '0;
      checkReg("recal DC", `RP_ADR_DC, '0);
      checkReg("recal DA", `RP_ADR_DA, '0);
      checkReg("recal DS", `RP_ADR_DS, dsExpect(1'b1, 1'b1, 1'b1));
      checkValue("recal attn", 1, attn);
      goFunc(`RP_FN_DRVCLR);
      checkReg("clear DS", `RP_ADR_DS, dsExpect(1'b0, 1'b0, 1'b1));
      checkReg("clear ER1", `RP_ADR_ER1, '0);
      checkValue("clear attn", 0, attn);

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rpDrive.sv ====
////////////////////////////////////////
// RP disk drive top
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

module rpDrive
(
   input  logic             clk,
   input  logic             rst,
   input  rpRegPkg::rpBusT  rpBus,
   input  rpRegPkg::regAdrT rdAdr,
   output rpRegPkg::rpWordT rdData,
   output logic             attn
);

   import rpRegPkg::*;
   import rpCmdPkg::*;

   // Controller strobes to address registers
   addrCmdT addrCmd;

   // Current disk address back to controller
   dcaT  dca;
   trkT  trk;
   sectT sect;

   // Track wrap carry from DA to DC
   logic incCyl;

   ////////////////////////////////////////
   // Controller
   ////////////////////////////////////////

   rpCtrl i_ctrl
   (
      .clk     (clk),
      .rst     (rst),
      .rpBus   (rpBus),
      .rdAdr   (rdAdr),
      .rdData  (rdData),
      .attn    (attn),
      .dca     (dca),
      .trk     (trk),
      .sect    (sect),
      .addrCmd (addrCmd)
   );

   ////////////////////////////////////////
   // Address registers
   ////////////////////////////////////////

   rpdc i_rpdc
   (
      .clk     (clk),
      .rst     (rst),
      .addrCmd (addrCmd),
      .data    (rpBus.data),
      .incCyl  (incCyl),
      .dca     (dca)
   );

   rpda i_rpda
   (
      .clk     (clk),
      .rst     (rst),
      .addrCmd (addrCmd),
      .data    (rpBus.data),
      .trk     (trk),
      .sect    (sect),
      .incCyl  (incCyl)
   );

endmodule

`default_nettype wire

// ==== rpCtrl.sv ====
////////////////////////////////////////
// RP drive controller
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

`include "rpDrive_consts.svh"

module rpCtrl
(
   input  logic              clk,
   input  logic              rst,
   input  rpRegPkg::rpBusT   rpBus,
   input  rpRegPkg::regAdrT  rdAdr,
   output rpRegPkg::rpWordT  rdData,
   output logic              attn,
   input  rpRegPkg::dcaT     dca,
   input  rpRegPkg::trkT     trk,
   input  rpRegPkg::sectT    sect,
   output rpCmdPkg::addrCmdT addrCmd
);

   import rpRegPkg::*;
   import rpCmdPkg::*;

   // Delay counter sized for the longer operation
   localparam int cntMax   = (`RP_SEEK_CYCLES > `RP_XFER_CYCLES) ?
                             `RP_SEEK_CYCLES : `RP_XFER_CYCLES;
   localparam int cntWidth = $clog2(cntMax);

   ctrlStateT           state;
   logic [cntWidth-1:0] cnt;
   logic [4:0]          funReg;
   logic                ata;
   logic                iae;
   logic                dry;
   logic                err;

   // Write decode
   logic       wrCs1;
   logic [4:0] fun;
   logic       goCmd;
   logic       addrOk;
   logic       posFun;
   logic       startSeek;
   logic       startRead;
   logic       badAddr;
   logic       doRecal;
   logic       doClear;
   logic       seekDone;

   // Read-back words
   rpWordT cs1Word;
   rpWordT dsWord;
   rpWordT er1Word;
   rpWordT daWord;
   rpWordT dcWord;

   ////////////////////////////////////////
   // Bus decode
   ////////////////////////////////////////

   // Ready whenever no operation is running
   assign dry = (state == stIdle);
   assign err = iae;

   assign wrCs1 = rpBus.wr && (rpBus.adr == `RP_ADR_CS1) && dry;
   assign fun   = rpBus.data[`RP_CS1_FUN];
   assign goCmd = wrCs1 && rpBus.data[`RP_CS1_GO];

   // Current address against drive geometry
   assign addrOk = (dca < dcaT'(`RP_NUM_CYL)) && (trk < trkT'(`RP_NUM_TRK))
                   && (sect < sectT'(`RP_NUM_SECT));

   // Only positioning and transfer use the address
   assign posFun    = (fun == `RP_FN_SEEK) || (fun == `RP_FN_READ);
   assign startSeek = goCmd && (fun == `RP_FN_SEEK) && addrOk;
   assign startRead = goCmd && (fun == `RP_FN_READ) && addrOk;
   assign badAddr   = goCmd && posFun && !addrOk;
   assign doRecal   = goCmd && (fun == `RP_FN_RECAL);
   assign doClear   = goCmd && (fun == `RP_FN_DRVCLR);
   assign seekDone  = (state == stSeek) && (cnt == '0);

   // Address register loads only when ready
   assign addrCmd.wrDc    = rpBus.wr && (rpBus.adr == `RP_ADR_DC) && dry;
   assign addrCmd.wrDa    = rpBus.wr && (rpBus.adr == `RP_ADR_DA) && dry;
   assign addrCmd.clr     = doRecal;
   // One early so DC carry lands by the time DRY rises
   assign addrCmd.incSect = (state == stXfer) && (cnt == cntWidth'(1));

   ////////////////////////////////////////
   // Function FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state  <= stIdle;
         cnt    <= '0;
         funReg <= `RP_FN_NOP;
      end
      else
      begin
         // Remember last function for CS1
         if (wrCs1)
            funReg <= fun;
         case (state)
            stIdle:
            begin
               if (startSeek)
               begin
                  state <= stSeek;
                  cnt   <= cntWidth'(`RP_SEEK_CYCLES - 1);
               end
               else if (startRead)
               begin
                  state <= stXfer;
                  cnt   <= cntWidth'(`RP_XFER_CYCLES - 1);
               end
            end
            stSeek, stXfer:
            begin
               if (cnt == '0)
                  state <= stIdle;
               else
                  cnt <= cnt - 1'b1;
            end
            default:
               state <= stIdle;
         endcase
      end
   end

   // Attention and address error bits cleared by drive clear
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ata <= 1'b0;
         iae <= 1'b0;
      end
      else if (doClear)
      begin
         ata <= 1'b0;
         iae <= 1'b0;
      end
      else
      begin
         if (seekDone || doRecal)
            ata <= 1'b1;
         if (badAddr)
            iae <= 1'b1;
      end
   end

   assign attn = ata;

   ////////////////////////////////////////
   // Read multiplexer
   ////////////////////////////////////////

   always_comb
   begin
      cs1Word                = '0;
      cs1Word[`RP_CS1_FUN]   = funReg;
      // GO reads back set while busy
      cs1Word[`RP_CS1_GO]    = ~dry;
      dsWord                 = '0;
      dsWord[`RP_DS_ATA]     = ata;
      dsWord[`RP_DS_ERR]     = err;
      dsWord[`RP_DS_DRY]     = dry;
      er1Word                = '0;
      er1Word[`RP_ER1_IAE]   = iae;
      daWord                 = '0;
      daWord[`RP_DA_TRK]     = trk;
      daWord[`RP_DA_SECT]    = sect;
      dcWord                 = '0;
      dcWord[`RP_DC_DCA]     = dca;
      case (rdAdr)
         `RP_ADR_CS1: rdData = cs1Word;
         `RP_ADR_DS:  rdData = dsWord;
         `RP_ADR_ER1: rdData = er1Word;
         `RP_ADR_DA:  rdData = daWord;
         `RP_ADR_DC:  rdData = dcWord;
         default:     rdData = '0;
      endcase
   end

   // Busy drive moves DC/DA only through the sector step
   assert property (@(posedge clk) disable iff (rst)
      (state != stIdle) && ($past(state) != stIdle) && !$past(addrCmd.incSect)
      && !$past(addrCmd.incSect, 2) |-> $stable({dca, trk, sect}));

   // Sector step comes one cycle before the transfer ends
   assert property (@(posedge clk) disable iff (rst)
      addrCmd.incSect |-> (state == stXfer) ##1 (state == stXfer && cnt == '0));

endmodule

`default_nettype wire

// ==== rpda.sv ====
////////////////////////////////////////
// RP track/sector register
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

`include "rpDrive_consts.svh"

module rpda
(
   input  logic              clk,
   input  logic              rst,
   input  rpCmdPkg::addrCmdT addrCmd,
   input  rpRegPkg::busDataT data,
   output rpRegPkg::trkT     trk,
   output rpRegPkg::sectT    sect,
   output logic              incCyl
);

   import rpRegPkg::*;

   // Desired track and sector
   trkT  trkReg;
   sectT sectReg;

   // Registered carry into the cylinder
   logic incCylReg;

   // Wrap points from the geometry
   logic lastSect;
   logic lastTrk;

   assign lastSect = (sectReg == sectT'(`RP_NUM_SECT - 1));
   assign lastTrk  = (trkReg == trkT'(`RP_NUM_TRK - 1));

   ////////////////////////////////////////
   // Track and sector
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         trkReg  <= '0;
         sectReg <= '0;
      end
      else if (addrCmd.clr)
      begin
         trkReg  <= '0;
         sectReg <= '0;
      end
      else if (addrCmd.wrDa)
      begin
         trkReg  <= trkT'(data[`RP_DA_TRK]);
         sectReg <= sectT'(data[`RP_DA_SECT]);
      end
      else if (addrCmd.incSect)
      begin
         if (lastSect)
         begin
            // Sector wraps, carry into track
            sectReg <= '0;
            if (lastTrk)
               trkReg <= '0;
            else
               trkReg <= trkReg + 1'b1;
         end
         else
            sectReg <= sectReg + 1'b1;
      end
   end

   // One-cycle carry to DC when the track wraps
   // DC therefore moves one cycle after DA
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         incCylReg <= 1'b0;
      else
         incCylReg <= addrCmd.incSect & ~addrCmd.clr & ~addrCmd.wrDa
                      & lastSect & lastTrk;
   end

   assign trk    = trkReg;
   assign sect   = sectReg;
   assign incCyl = incCylReg;

endmodule

`default_nettype wire

// ==== rpdc.sv ====
////////////////////////////////////////
// RP desired cylinder register
////////////////////////////////////////

`default_nettype none
`timescale 1ns/100ps

`include "rpDrive_consts.svh"

module rpdc
(
   input  logic              clk,
   input  logic              rst,
   input  rpCmdPkg::addrCmdT addrCmd,
   input  rpRegPkg::busDataT data,
   input  logic              incCyl,
   output rpRegPkg::dcaT     dca
);

   import rpRegPkg::*;

   // Desired cylinder address
   dcaT dcaReg;

   ////////////////////////////////////////
   // Cylinder register
   ////////////////////////////////////////

   // Clear wins, then host load, then carry from DA
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dcaReg <= '0;
      else if (addrCmd.clr)
         dcaReg <= '0;
      else if (addrCmd.wrDc)
         dcaReg <= dcaT'(data[`RP_DC_DCA]);
      else if (incCyl)
         dcaReg <= dcaReg + 1'b1;
   end

   assign dca = dcaReg;

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   // Host load must never collide with a carry out of DA
   assert property (@(posedge clk) disable iff (rst)
      !(addrCmd.wrDc && incCyl));

endmodule

`default_nettype wire

// ==== rpCmdPkg.sv ====
////////////////////////////////////////
// RP controller command types
////////////////////////////////////////

`default_nettype none

package rpCmdPkg;

   // Function FSM states
   typedef enum logic [1:0]
   {
      stIdle,
      stSeek,
      stXfer
   } ctrlStateT;

   // Strobes from controller to address registers
   // Each one is high for a single cycle
   typedef struct packed
   {
      logic wrDc;
      logic wrDa;
      logic clr;
      logic incSect;
   } addrCmdT;

endpackage

`default_nettype wire

// ==== rpRegPkg.sv ====
////////////////////////////////////////
// RP register bus types
////////////////////////////////////////

`default_nettype none

package rpRegPkg;

   // Host write data, full 36-bit word
   typedef logic [35:0] busDataT;

   // One drive register as seen by the host
   typedef logic [15:0] rpWordT;

   // Register select code
   typedef logic [4:0] regAdrT;

   //
   // Address fields
   //

   // Desired cylinder
   typedef logic [9:0] dcaT;

   // Desired track
   typedef logic [4:0] trkT;

   // Desired sector
   typedef logic [4:0] sectT;

   // Host write bus
   // wr is a single-cycle strobe per write
   typedef struct packed
   {
      logic    wr;
      regAdrT  adr;
      busDataT data;
   } rpBusT;

endpackage

`default_nettype wire

// ==== rpDrive_consts.svh ====
////////////////////////////////////////
// RP drive constants
////////////////////////////////////////

`ifndef RPDRIVE_CONSTS_SVH
`define RPDRIVE_CONSTS_SVH

// Drive geometry
`define RP_NUM_CYL      815
`define RP_NUM_TRK      19
`define RP_NUM_SECT     20

// Operation delays in clock cycles
`define RP_SEEK_CYCLES  16
`define RP_XFER_CYCLES  8

// Register select codes
`define RP_ADR_CS1      5'd0
`define RP_ADR_DS       5'd1
`define RP_ADR_ER1      5'd2
`define RP_ADR_DA       5'd5
`define RP_ADR_DC       5'd9

// Function codes, CS1 bits 5:1
`define RP_FN_NOP       5'o00
`define RP_FN_SEEK      5'o02
`define RP_FN_RECAL     5'o03
`define RP_FN_DRVCLR    5'o04
`define RP_FN_READ      5'o34

// CS1 fields
`define RP_CS1_GO       0
`define RP_CS1_FUN      5:1

// Status and error bit positions
`define RP_DS_ATA       15
`define RP_DS_ERR       14
`define RP_DS_DRY       7
`define RP_ER1_IAE      10

// Address fields within a write word
`define RP_DA_SECT      4:0
`define RP_DA_TRK       12:8
`define RP_DC_DCA       9:0

`endif
